// File: apb_pkg.sv
`default_nettype none

`include "apb_reg_macros.svh"

package apb_pkg;

    typedef logic [`APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [`APB_DATA_W-1:0] apb_data_t;

    typedef struct packed {
        logic       psel;
        logic       penable;
        logic       pwrite;
        apb_addr_t  paddr;
        apb_data_t  pwdata;
    } apb_req_t;

    typedef struct packed {
        logic       pready;
        logic       pslverr;
        apb_data_t  prdata;
    } apb_rsp_t;

    typedef enum logic [1:0] {
        S_IDLE = 2'd0,
        S_WAIT = 2'd1,
        S_ACK  = 2'd2
    } fsm_state_e;

endpackage

`default_nettype wire

// File: apb_reg_macros.svh
`ifndef APB_REG_MACROS_SVH
`define APB_REG_MACROS_SVH

// bus widths
`define APB_ADDR_W      32
`define APB_DATA_W      32

// register map, byte addresses
`define REG_FAST_BASE   32'h0000_0000
`define REG_FAST_NUM    8
`define REG_SLOW_BASE   32'h0000_0100
`define REG_SLOW_NUM    16

// cycles from the setup edge to the slow ack
`define REG_SLOW_LAT    4

`define TMR_LIMIT       16              // wait cycles before timeout
`define TMOUT_PATTERN   32'hdead_1eaf   // prdata on timeout

`endif

// File: apb_reg_top.sv
`default_nettype none

module apb_reg_top
    import apb_pkg::*;
    import reg_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp
);

    // **************************************************
    // internal nets
    // **************************************************
    reg_req_t reg_req;      // bridge to register bank
    reg_rsp_t reg_rsp;
    logic     tmr_rst;
    logic     tmr_tmout;

    // APB handshake
    mst_fsm u_mst_fsm (
        .clk       (clk),
        .rst_n     (rst_n),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .reg_req   (reg_req),
        .reg_rsp   (reg_rsp),
        .tmr_tmout (tmr_tmout),
        .tmr_rst   (tmr_rst)
    );

    // wait-cycle watchdog
    bus_timer u_bus_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .tmr_rst   (tmr_rst),
        .tmr_tmout (tmr_tmout)
    );

    reg_bank u_reg_bank (
        .clk       (clk),
        .rst_n     (rst_n),
        .reg_req   (reg_req),
        .reg_rsp   (reg_rsp)
    );

endmodule

`default_nettype wire

// File: bus_timer.sv
`default_nettype none

`include "apb_reg_macros.svh"

module bus_timer
    import reg_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic tmr_rst,
    output logic tmr_tmout
);

    localparam tmr_cnt_t CNT_LAST = tmr_cnt_t'(`TMR_LIMIT - 1);

    tmr_cnt_t cnt;

    // saturating wait counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (tmr_rst) begin
            cnt <= '0;
        end else if (cnt != '1) begin
            cnt <= cnt + tmr_cnt_t'(1);
        end
    end

    // registered so it lands in the TMR_LIMIT-th wait cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tmr_tmout <= 1'b0;
        end else begin
            tmr_tmout <= !tmr_rst && (cnt == CNT_LAST);
        end
    end

    // a timeout always closes the transfer
    a_tmout_closes: assert property (
        @(posedge clk) disable iff (!rst_n)
        tmr_tmout |-> tmr_rst
    );

endmodule

`default_nettype wire

// File: flist.f
+incdir+.
apb_pkg.sv
reg_pkg.sv
bus_timer.sv
reg_bank.sv
mst_fsm.sv
apb_reg_top.sv
tb_apb_reg_top.sv

// File: mst_fsm.sv
`default_nettype none

`include "apb_reg_macros.svh"

module mst_fsm
    import apb_pkg::*;
    import reg_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp,
    output reg_req_t reg_req,
    input  reg_rsp_t reg_rsp,
    input  logic     tmr_tmout,
    output logic     tmr_rst
);

    fsm_state_e state;
    fsm_state_e next_state;
    logic       setup;
    apb_data_t  rd_data_ff;

    assign setup = apb_req.psel & ~apb_req.penable;

    // **************************************************
    // state machine
    // **************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            S_IDLE: begin
                if (setup) begin
                    next_state = reg_rsp.ack_vld ? S_ACK : S_WAIT;
                end
            end
            S_WAIT: begin
                if (reg_rsp.ack_vld || tmr_tmout) begin
                    next_state = S_IDLE;
                end
            end
            S_ACK: next_state = S_IDLE;
            default: next_state = S_IDLE;
        endcase
    end

    // timer runs only while a transfer is open
    assign tmr_rst = (next_state == S_IDLE);

    // **************************************************
    // native request
    // **************************************************
    always_comb begin
        reg_req = '0;
        if (setup) begin
            reg_req.req_vld = 1'b1;
            reg_req.wr_en   = apb_req.pwrite;
            reg_req.rd_en   = ~apb_req.pwrite;
            reg_req.addr    = apb_req.paddr;
            reg_req.wr_data = apb_req.pwdata;
        end
    end

    // fast read data is shown one cycle later in S_ACK
    always_ff @(posedge clk) begin
        if (setup && reg_rsp.ack_vld) begin
            rd_data_ff <= reg_rsp.rd_data;
        end
    end

    // **************************************************
    // APB response
    // **************************************************
    always_comb begin
        apb_rsp = '0;
        case (state)
            S_ACK: begin
                apb_rsp.pready = 1'b1;
                apb_rsp.prdata = rd_data_ff;
            end
            S_WAIT: begin
                if (reg_rsp.ack_vld) begin           // late ack wins over timeout
                    apb_rsp.pready = 1'b1;
                    apb_rsp.prdata = reg_rsp.rd_data;
                end else if (tmr_tmout) begin
                    apb_rsp.pready  = 1'b1;
                    apb_rsp.pslverr = 1'b1;
                    apb_rsp.prdata  = `TMOUT_PATTERN;
                end
            end
            default: apb_rsp = '0;
        endcase
    end

    // answers only in an access phase
    a_ready_in_access: assert property (
        @(posedge clk) disable iff (!rst_n)
        apb_rsp.pready |-> (apb_req.psel && apb_req.penable)
    );

    // an error ends a full TMR_LIMIT wait
    a_err_after_wait: assert property (
        @(posedge clk) disable iff (!rst_n)
        apb_rsp.pslverr |-> (apb_rsp.pready && $past(state == S_WAIT, `TMR_LIMIT - 1))
    );

endmodule

`default_nettype wire

// File: reg_bank.sv
`default_nettype none

`include "apb_reg_macros.svh"

module reg_bank
    import apb_pkg::*;
    import reg_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  reg_req_t reg_req,
    output reg_rsp_t reg_rsp
);

    localparam int FAST_IDX_W = $clog2(`REG_FAST_NUM);
    localparam int LAT_W      = $clog2(`REG_SLOW_LAT) + 1;

    apb_data_t             fast_regs [`REG_FAST_NUM];
    apb_data_t             slow_mem  [`REG_SLOW_NUM];

    apb_addr_t             fast_off;
    apb_addr_t             slow_off;
    logic                  fast_hit;
    logic                  slow_hit;
    logic [FAST_IDX_W-1:0] fast_idx;

    logic                  slow_pend;
    logic [LAT_W-1:0]      slow_cnt;
    logic                  slow_done;
    slow_idx_t             slow_idx;
    apb_data_t             slow_wdata;
    logic                  slow_wr;

    // **************************************************
    // address decode
    // **************************************************
    assign fast_off = reg_req.addr - `REG_FAST_BASE;   // wraps below base, so a miss
    assign slow_off = reg_req.addr - `REG_SLOW_BASE;
    assign fast_hit = reg_req.req_vld && (fast_off < apb_addr_t'(`REG_FAST_NUM * 4));
    assign slow_hit = reg_req.req_vld && (slow_off < apb_addr_t'(`REG_SLOW_NUM * 4));
    assign fast_idx = fast_off[FAST_IDX_W+1:2];

    // fast registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_FAST_NUM; i++) begin
                fast_regs[i] <= '0;
            end
        end else if (fast_hit && reg_req.wr_en) begin
            fast_regs[fast_idx] <= reg_req.wr_data;
        end
    end

    // **************************************************
    // slow region
    // **************************************************
    assign slow_done = slow_pend && (slow_cnt == LAT_W'(`REG_SLOW_LAT - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slow_pend <= 1'b0;
            slow_cnt  <= '0;
        end else if (slow_hit) begin
            slow_pend <= 1'b1;
            slow_cnt  <= '0;
        end else if (slow_done) begin
            slow_pend <= 1'b0;
        end else if (slow_pend) begin
            slow_cnt  <= slow_cnt + LAT_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (slow_hit) begin
            slow_idx   <= slow_idx_t'(slow_off >> 2);
            slow_wdata <= reg_req.wr_data;
            slow_wr    <= reg_req.wr_en;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_SLOW_NUM; i++) begin
                slow_mem[i] <= '0;
            end
        end else if (slow_done && slow_wr) begin
            slow_mem[slow_idx] <= slow_wdata;   // write lands in the ack cycle
        end
    end

    // response, unmapped requests get nothing
    always_comb begin
        reg_rsp = '0;
        if (fast_hit) begin
            reg_rsp.ack_vld = 1'b1;
            if (reg_req.rd_en) begin
                reg_rsp.rd_data = fast_regs[fast_idx];
            end
        end else if (slow_done) begin
            reg_rsp.ack_vld = 1'b1;
            if (!slow_wr) begin
                reg_rsp.rd_data = slow_mem[slow_idx];
            end
        end
    end

    a_no_req_while_pending: assert property (
        @(posedge clk) disable iff (!rst_n)
        slow_pend |-> !reg_req.req_vld
    );

endmodule

`default_nettype wire

// File: reg_pkg.sv
`default_nettype none

`include "apb_reg_macros.svh"

package reg_pkg;

    import apb_pkg::*;

    // native request, strobes are valid in the setup cycle only
    typedef struct packed {
        logic       req_vld;
        logic       wr_en;
        logic       rd_en;
        apb_addr_t  addr;
        apb_data_t  wr_data;
    } reg_req_t;

    typedef struct packed {
        logic       ack_vld;    // one-cycle pulse
        apb_data_t  rd_data;
    } reg_rsp_t;

    // word index into the slow region
    typedef logic [$clog2(`REG_SLOW_NUM)-1:0] slow_idx_t;

    // wait counter, wide enough to hold TMR_LIMIT
    typedef logic [$clog2(`TMR_LIMIT+1)-1:0] tmr_cnt_t;

endpackage

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# build and run the APB register bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f flist.f --top-module tb_apb_reg_top
./obj_dir/Vtb_apb_reg_top | tee sim.log

if grep -qx "PASS: all tests" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

// File: tb_apb_reg_top.sv
`default_nettype none

`include "apb_reg_macros.svh"

module tb_apb_reg_top
    import apb_pkg::*;
();

    localparam int REGION_FAST = 0;
    localparam int REGION_SLOW = 1;
    localparam int REGION_NONE = 2;
    localparam int FAST_W      = $clog2(`REG_FAST_NUM);
    localparam int SLOW_W      = $clog2(`REG_SLOW_NUM);
    localparam int NUM_XFERS   = 121;   // 24 + 16 + 32 + 9 + 40

    logic      clk;
    logic      rst_n;
    apb_req_t  apb_req;
    apb_rsp_t  apb_rsp;

    apb_data_t fast_model [`REG_FAST_NUM];
    apb_data_t slow_model [`REG_SLOW_NUM];
    integer    seed;
    int        err_count;
    int        check_count;

    apb_reg_top u_apb_reg_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    always #4 clk = ~clk;

    // **************************************************
    // helpers
    // **************************************************
    task automatic check(input string name, input apb_data_t got, input apb_data_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    function automatic int addr_region(input apb_addr_t addr);
        longint a;
        a = addr;
        if (a >= longint'(`REG_FAST_BASE) && a < longint'(`REG_FAST_BASE) + `REG_FAST_NUM * 4)
            return REGION_FAST;
        if (a >= longint'(`REG_SLOW_BASE) && a < longint'(`REG_SLOW_BASE) + `REG_SLOW_NUM * 4)
            return REGION_SLOW;
        return REGION_NONE;
    endfunction

    function automatic int expected_cycles(input int region);
        case (region)
            REGION_FAST: return 2;
            REGION_SLOW: return 1 + `REG_SLOW_LAT;
            default:     return 1 + `TMR_LIMIT;    // only the timer ends it
        endcase
    endfunction

    function automatic apb_addr_t fast_addr(input int idx);
        return apb_addr_t'(`REG_FAST_BASE + idx * 4);
    endfunction

    function automatic apb_addr_t slow_addr(input int idx);
        return apb_addr_t'(`REG_SLOW_BASE + idx * 4);
    endfunction

    // setup phase, then access phase held until pready
    task automatic drive_transfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                                  output apb_data_t rdata, output logic err, output int cycles);
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= wr;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= wr ? wdata : '0;
        cycles = 1;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        cycles++;
        @(negedge clk);
        while (!apb_rsp.pready) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data,
                             output logic err, output int cycles);
        apb_data_t rdata_ignored;
        drive_transfer(1'b1, addr, data, rdata_ignored, err, cycles);
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data,
                            output logic err, output int cycles);
        drive_transfer(1'b0, addr, '0, data, err, cycles);
    endtask

    task automatic bus_idle(input int n);
        repeat (n) begin
            @(posedge clk);
            apb_req <= '0;
        end
    endtask

    // one transfer, checked against the register map rules and the model
    task automatic access_and_check(input logic wr, input apb_addr_t addr, input apb_data_t wdata);
        apb_data_t rdata;
        logic      err;
        int        cycles;
        int        region;
        int        idx;
        region = addr_region(addr);
        if (wr)
            apb_write(addr, wdata, err, cycles);
        else
            apb_read(addr, rdata, err, cycles);
        check($sformatf("cycles @%08h", addr), 32'(cycles), 32'(expected_cycles(region)));
        check($sformatf("pslverr @%08h", addr), 32'(err),
              (region == REGION_NONE) ? 32'd1 : 32'd0);
        case (region)
            REGION_FAST: begin
                idx = int'((addr - `REG_FAST_BASE) >> 2);
                if (wr)
                    fast_model[FAST_W'(idx)] = wdata;
                else
                    check($sformatf("prdata @%08h", addr), rdata, fast_model[FAST_W'(idx)]);
            end
            REGION_SLOW: begin
                idx = int'((addr - `REG_SLOW_BASE) >> 2);
                if (wr)
                    slow_model[SLOW_W'(idx)] = wdata;
                else
                    check($sformatf("prdata @%08h", addr), rdata, slow_model[SLOW_W'(idx)]);
            end
            default: begin
                if (!wr)
                    check($sformatf("prdata @%08h", addr), rdata, `TMOUT_PATTERN);
            end
        endcase
    endtask

    // **************************************************
    // directed tests
    // **************************************************
    task automatic check_reset_state();
        @(negedge clk);
        check("pready", 32'(apb_rsp.pready), 32'd0);
        check("pslverr", 32'(apb_rsp.pslverr), 32'd0);
        for (int i = 0; i < `REG_FAST_NUM; i++)
            access_and_check(1'b0, fast_addr(i), '0);
        for (int i = 0; i < `REG_SLOW_NUM; i++)
            access_and_check(1'b0, slow_addr(i), '0);
    endtask

    task automatic fast_reg_rw();
        for (int i = 0; i < `REG_FAST_NUM; i++)
            access_and_check(1'b1, fast_addr(i), $random(seed));
        for (int i = 0; i < `REG_FAST_NUM; i++)
            access_and_check(1'b0, fast_addr(i), '0);
    endtask

    task automatic slow_region_rw();
        for (int i = 0; i < `REG_SLOW_NUM; i++)
            access_and_check(1'b1, slow_addr(i), $random(seed));
        for (int i = 0; i < `REG_SLOW_NUM; i++)
            access_and_check(1'b0, slow_addr(i), '0);
    endtask

    task automatic unmapped_timeout();
        apb_addr_t holes [3];
        holes = '{32'h0000_0080, 32'h0000_0200, 32'hffff_fff0};
        for (int i = 0; i < 3; i++) begin
            access_and_check(1'b0, holes[i], '0);
            access_and_check(1'b1, holes[i], $random(seed));
            access_and_check(1'b0, fast_addr(i), '0);   // timer must be cleared by now
        end
    endtask

    // back to back, each setup right after the previous pready
    task automatic mixed_traffic();
        int        sel;
        int        idx;
        logic      wr;
        apb_addr_t addr;
        for (int n = 0; n < 40; n++) begin
            sel = $unsigned($random(seed)) % 4;
            idx = $unsigned($random(seed)) % 16;
            wr  = 1'($random(seed));
            case (sel)
                0, 1:    addr = fast_addr(idx % `REG_FAST_NUM);
                2:       addr = slow_addr(idx);
                default: addr = apb_addr_t'(32'h0000_0040 + idx * 4);  // gap below slow region
            endcase
            access_and_check(wr, addr, $random(seed));
        end
    endtask

    // **************************************************
    // main sequence and watchdog
    // **************************************************
    initial begin
        seed        = 65292;
        err_count   = 0;
        check_count = 0;
        clk         = 1'b0;
        rst_n       = 1'b0;
        apb_req     = '0;
        fast_model  = '{default: '0};
        slow_model  = '{default: '0};
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        check_reset_state();
        bus_idle(2);
        fast_reg_rw();
        bus_idle(2);
        slow_region_rw();
        bus_idle(2);
        unmapped_timeout();
        bus_idle(2);
        mixed_traffic();
        bus_idle(2);
        $display("errors: %0d, checks: %0d", err_count, check_count);
        if (err_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        repeat (NUM_XFERS * (`TMR_LIMIT + 4) + 100) @(posedge clk);
        $display("ERROR: watchdog expired, a transfer never completed");
        $display("errors: %0d, checks: %0d", err_count, check_count);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire
